// ==== common/dcmp_stream_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// byte stream types and queue sizing
////////////////////////////////////////////////////////////////////////////

package dcmp_stream_pkg;

	// width of one stream byte on both outer ports
	localparam int BYTE_W = 8;

	typedef logic [BYTE_W-1:0] byte_t;

	// descriptor queue between the two threads
	// up to this many runs can be in flight
	localparam int RUN_FIFO_DEPTH = 4;

	// raw payload queue
	// deep enough to cover a short raw run while the emitter drains fills
	localparam int DATA_FIFO_DEPTH = 16;

endpackage

// ==== common/dcmp_format_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// compressed stream format and run descriptor
////////////////////////////////////////////////////////////////////////////

package dcmp_format_pkg;

	import dcmp_stream_pkg::*;

	// run length field, stored as length minus one
	localparam int LEN_W = 12;

	typedef logic [LEN_W-1:0] run_len_t;

	// what the back thread does with a run
	typedef enum logic {
		RUN_RAW  = 1'b0,
		RUN_FILL = 1'b1
	} run_kind_t;

	// header kind codes in bits 6:4 of the first header byte
	// anything not listed here expands as a zero fill
	localparam logic [2:0] HDR_KIND_RAW  = 3'b101;
	localparam logic [2:0] HDR_KIND_ZERO = 3'b000;
	localparam logic [2:0] HDR_KIND_ONES = 3'b111;
	localparam logic [2:0] HDR_KIND_VAR  = 3'b010;

	// set when a second header byte carries length bits 11:4
	localparam int HDR_EXT_BIT = 7;

	// one entry of the descriptor queue
	typedef struct packed {
		run_kind_t kind;
		run_len_t  len;
		byte_t     fill;
	} run_desc_t;

endpackage

// ==== hw/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo
	import dcmp_stream_pkg::*;
#(
	parameter int DEPTH = 4,
	parameter type payload_t = byte_t
) (
	input  logic     clk,
	input  logic     nreset,
	input  logic     clear,
	input  logic     push,
	input  payload_t din,
	input  logic     pop,
	output payload_t dout,
	output logic     full,
	output logic     empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// head entry is always visible
	assign dout  = mem[rd_ptr];
	assign full  = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (!nreset || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				if (wr_ptr == PTR_W'(DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				if (rd_ptr == PTR_W'(DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			// simultaneous push and pop leaves the level alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// queue protocol, both producer and consumer live in other modules
	////////////////////////////////////////////////////////////////////////////

	a_no_push_when_full: assert property (
		@(posedge clk) disable iff (!nreset || clear)
		full |-> !push
	) else $error("push into a full queue");

	a_no_pop_when_empty: assert property (
		@(posedge clk) disable iff (!nreset || clear)
		empty |-> !pop
	) else $error("pop from an empty queue");

endmodule

// ==== decompressor/header_parser.sv ====
`timescale 1ns/1ps

module header_parser
	import dcmp_stream_pkg::*;
	import dcmp_format_pkg::*;
(
	input  logic      clk,
	input  logic      nreset,
	input  logic      control_ready,

	// flash side
	input  byte_t     flash_data,
	input  logic      flash_data_ready,
	output logic      flash_data_read,

	// descriptor queue
	output logic      run_push,
	output run_desc_t run_desc,
	input  logic      run_full,

	// raw payload queue
	output logic      data_push,
	output byte_t     data_byte,
	input  logic      data_full
);

	typedef enum logic [2:0] {
		P_IDLE,
		P_HEADER,
		P_SECOND_HEADER,
		P_VAR_DATA,
		P_DESC_PUSH,
		P_RAW_DATA
	} parse_state_t;

	parse_state_t state;
	parse_state_t state_next;

	run_desc_t  desc_q;
	logic       is_var_q;
	run_len_t   raw_cnt;
	logic [2:0] hdr_kind;
	logic       raw_take;

	// kind code sits in bits 6:4 of the first header byte
	assign hdr_kind = flash_data[6:4];

	assign raw_take = (state == P_RAW_DATA) && flash_data_ready && !data_full;

	always_comb begin
		flash_data_read = 1'b0;
		case (state)
			P_HEADER, P_SECOND_HEADER, P_VAR_DATA:
				flash_data_read = flash_data_ready;
			P_RAW_DATA:
				flash_data_read = flash_data_ready && !data_full;
			default:
				flash_data_read = 1'b0;
		endcase
	end

	assign run_push  = (state == P_DESC_PUSH) && !run_full;
	assign run_desc  = desc_q;
	assign data_push = raw_take;
	assign data_byte = flash_data;

	////////////////////////////////////////////////////////////////////////////
	// front thread FSM
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			P_IDLE:
				state_next = P_HEADER;
			P_HEADER:
				if (flash_data_ready) begin
					if (flash_data[HDR_EXT_BIT])
						state_next = P_SECOND_HEADER;
					else if (hdr_kind == HDR_KIND_VAR)
						state_next = P_VAR_DATA;
					else
						state_next = P_DESC_PUSH;
				end
			P_SECOND_HEADER:
				if (flash_data_ready)
					state_next = is_var_q ? P_VAR_DATA : P_DESC_PUSH;
			P_VAR_DATA:
				if (flash_data_ready)
					state_next = P_DESC_PUSH;
			P_DESC_PUSH:
				// stall here while the descriptor queue is full
				if (!run_full)
					state_next = (desc_q.kind == RUN_RAW) ? P_RAW_DATA : P_HEADER;
			P_RAW_DATA:
				if (raw_take && raw_cnt == desc_q.len)
					state_next = P_HEADER;
			default:
				state_next = P_IDLE;
		endcase
		if (!control_ready)
			state_next = P_IDLE;
	end

	always_ff @(posedge clk) begin
		if (!nreset)
			state <= P_IDLE;
		else
			state <= state_next;
	end

	// descriptor fields collected from the header bytes
	always_ff @(posedge clk) begin
		if (state == P_HEADER && flash_data_ready) begin
			desc_q.len  <= run_len_t'(flash_data[3:0]);
			desc_q.kind <= (hdr_kind == HDR_KIND_RAW) ? RUN_RAW : RUN_FILL;
			is_var_q    <= (hdr_kind == HDR_KIND_VAR);
			case (hdr_kind)
				HDR_KIND_ONES: desc_q.fill <= 8'hFF;
				HDR_KIND_ZERO: desc_q.fill <= 8'h00;
				default:       desc_q.fill <= 8'h00;
			endcase
		end
		if (state == P_SECOND_HEADER && flash_data_ready)
			desc_q.len[LEN_W-1:4] <= flash_data;
		// variable fill value follows the header
		if (state == P_VAR_DATA && flash_data_ready)
			desc_q.fill <= flash_data;
	end

	// raw bytes copied so far in the current run
	always_ff @(posedge clk) begin
		if (state == P_DESC_PUSH)
			raw_cnt <= '0;
		else if (raw_take)
			raw_cnt <= raw_cnt + 1'b1;
	end

	// a raw run never copies more payload than its length
	a_raw_within_len: assert property (
		@(posedge clk) disable iff (!nreset)
		raw_take |-> raw_cnt <= desc_q.len
	) else $error("raw payload read past the run length");

endmodule

// ==== decompressor/run_emitter.sv ====
`timescale 1ns/1ps

module run_emitter
	import dcmp_stream_pkg::*;
	import dcmp_format_pkg::*;
(
	input  logic      clk,
	input  logic      nreset,
	input  logic      control_ready,

	// descriptor queue head
	input  run_desc_t run_desc,
	input  logic      run_empty,
	output logic      run_pop,

	// raw payload queue head
	input  byte_t     data_byte,
	input  logic      data_empty,
	output logic      data_pop,

	// FPGA configuration side
	output byte_t     fpga_data,
	output logic      fpga_data_ready,
	input  logic      fpga_data_read
);

	typedef enum logic [1:0] {
		E_IDLE,
		E_FETCH,
		E_FILL,
		E_RAW
	} emit_state_t;

	emit_state_t state;
	emit_state_t state_next;

	run_desc_t desc_q;
	run_len_t  cnt;
	logic      xfer;
	logic      last;

	assign run_pop = (state == E_FETCH) && !run_empty;

	// fill runs are always ready, raw runs wait on the payload queue
	assign fpga_data_ready = (state == E_FILL) || (state == E_RAW && !data_empty);
	assign fpga_data       = (state == E_FILL) ? desc_q.fill : data_byte;

	assign xfer     = fpga_data_ready && fpga_data_read;
	assign data_pop = (state == E_RAW) && xfer;
	assign last     = (cnt == desc_q.len);

	////////////////////////////////////////////////////////////////////////////
	// back thread FSM
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			E_IDLE:
				state_next = E_FETCH;
			E_FETCH:
				if (!run_empty)
					state_next = (run_desc.kind == RUN_FILL) ? E_FILL : E_RAW;
			E_FILL, E_RAW:
				if (xfer && last)
					state_next = E_FETCH;
			default:
				state_next = E_IDLE;
		endcase
		if (!control_ready)
			state_next = E_IDLE;
	end

	always_ff @(posedge clk) begin
		if (!nreset)
			state <= E_IDLE;
		else
			state <= state_next;
	end

	// current run and bytes sent in it
	always_ff @(posedge clk) begin
		if (run_pop) begin
			desc_q <= run_desc;
			cnt    <= '0;
		end else if (xfer) begin
			cnt <= cnt + 1'b1;
		end
	end

	// a stalled byte must wait unchanged for the sink
	a_hold_while_stalled: assert property (
		@(posedge clk) disable iff (!nreset || !control_ready)
		fpga_data_ready && !fpga_data_read |=> fpga_data_ready && $stable(fpga_data)
	) else $error("fpga_data changed while stalled");

endmodule

// ==== decompressor/cfg_decompressor.sv ====
`timescale 1ns/1ps

module cfg_decompressor
	import dcmp_stream_pkg::*;
	import dcmp_format_pkg::*;
(
	input  logic  clk,
	input  logic  nreset,
	input  logic  control_ready,

	input  byte_t flash_data,
	input  logic  flash_data_ready,
	output logic  flash_data_read,

	output byte_t fpga_data,
	output logic  fpga_data_ready,
	input  logic  fpga_data_read
);

	// descriptor path
	logic      run_push;
	logic      run_pop;
	logic      run_full;
	logic      run_empty;
	run_desc_t run_desc_in;
	run_desc_t run_desc_head;

	// raw payload path
	logic      data_push;
	logic      data_pop;
	logic      data_full;
	logic      data_empty;
	byte_t     data_in;
	byte_t     data_head;

	header_parser parser (
		.clk              (clk),
		.nreset           (nreset),
		.control_ready    (control_ready),
		.flash_data       (flash_data),
		.flash_data_ready (flash_data_ready),
		.flash_data_read  (flash_data_read),
		.run_push         (run_push),
		.run_desc         (run_desc_in),
		.run_full         (run_full),
		.data_push        (data_push),
		.data_byte        (data_in),
		.data_full        (data_full)
	);

	sync_fifo #(
		.DEPTH     (RUN_FIFO_DEPTH),
		.payload_t (run_desc_t)
	) run_queue (
		.clk    (clk),
		.nreset (nreset),
		.clear  (!control_ready),
		.push   (run_push),
		.din    (run_desc_in),
		.pop    (run_pop),
		.dout   (run_desc_head),
		.full   (run_full),
		.empty  (run_empty)
	);

	sync_fifo #(
		.DEPTH     (DATA_FIFO_DEPTH),
		.payload_t (byte_t)
	) data_queue (
		.clk    (clk),
		.nreset (nreset),
		.clear  (!control_ready),
		.push   (data_push),
		.din    (data_in),
		.pop    (data_pop),
		.dout   (data_head),
		.full   (data_full),
		.empty  (data_empty)
	);

	run_emitter emitter (
		.clk             (clk),
		.nreset          (nreset),
		.control_ready   (control_ready),
		.run_desc        (run_desc_head),
		.run_empty       (run_empty),
		.run_pop         (run_pop),
		.data_byte       (data_head),
		.data_empty      (data_empty),
		.data_pop        (data_pop),
		.fpga_data       (fpga_data),
		.fpga_data_ready (fpga_data_ready),
		.fpga_data_read  (fpga_data_read)
	);

endmodule

// ==== tests/tb_stream_model.svh ====
////////////////////////////////////////////////////////////////////////////
// compressed stream building
////////////////////////////////////////////////////////////////////////////

typedef byte_t byte_q_t[$];

// one header byte, or two when the length needs bits 11:4
function automatic void put_header(ref byte_q_t s, input logic [2:0] code,
		input int len_m1, input bit force_ext);
	run_len_t len;
	logic ext;
	len = run_len_t'(len_m1);
	ext = force_ext || (len_m1 > 15);
	s.push_back({ext, code, len[3:0]});
	if (ext)
		s.push_back(len[11:4]);
endfunction

function automatic void add_raw(ref byte_q_t s, input int len_m1, input bit force_ext);
	int n;
	put_header(s, 3'b101, len_m1, force_ext);
	for (n = 0; n <= len_m1; n++)
		s.push_back(byte_t'($urandom));
endfunction

// value only travels in the stream for variable fills
function automatic void add_fill(ref byte_q_t s, input logic [2:0] code, input int len_m1,
		input byte_t value, input bit force_ext);
	put_header(s, code, len_m1, force_ext);
	if (code == 3'b010)
		s.push_back(value);
endfunction

function automatic void random_runs(ref byte_q_t s, input int runs);
	int r;
	int len_m1;
	logic [2:0] code;
	for (r = 0; r < runs; r++) begin
		code = 3'($urandom_range(7));
		// mostly short runs, now and then a long one
		if ($urandom_range(9) == 0)
			len_m1 = $urandom_range(300);
		else
			len_m1 = $urandom_range(24);
		if (code == 3'b101)
			add_raw(s, len_m1, $urandom_range(3) == 0);
		else
			add_fill(s, code, len_m1, byte_t'($urandom), $urandom_range(3) == 0);
	end
endfunction

////////////////////////////////////////////////////////////////////////////
// reference expansion
////////////////////////////////////////////////////////////////////////////

function automatic byte_q_t expand(input byte_q_t comp);
	byte_q_t plain;
	byte_t hdr;
	byte_t fill;
	int len;
	int i;
	int n;
	i = 0;
	while (i < comp.size()) begin
		hdr = comp[i];
		i++;
		len = int'(hdr[3:0]);
		if (hdr[7]) begin
			len = int'({comp[i], hdr[3:0]});
			i++;
		end
		if (hdr[6:4] == 3'b101) begin
			for (n = 0; n <= len; n++) begin
				plain.push_back(comp[i]);
				i++;
			end
		end else begin
			// unknown codes expand like a zero fill
			fill = 8'h00;
			if (hdr[6:4] == 3'b111)
				fill = 8'hFF;
			if (hdr[6:4] == 3'b010) begin
				fill = comp[i];
				i++;
			end
			for (n = 0; n <= len; n++)
				plain.push_back(fill);
		end
	end
	return plain;
endfunction

////////////////////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////////////////////

task automatic check_byte(input string name, input byte_t got, input byte_t exp);
	if (got !== exp) begin
		$display("Error at %0t: %s expected %02h, got %02h", $time, name, exp, got);
		stop_on_error();
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("Error at %0t: %s expected %b, got %b", $time, name, exp, got);
		stop_on_error();
	end
endtask

task automatic check_count(input string name, input int got, input int exp);
	if (got != exp) begin
		$display("Error at %0t: %s expected %0d, got %0d", $time, name, exp, got);
		stop_on_error();
	end
endtask

// ==== tests/tb_cfg_decompressor.sv ====
`timescale 1ns/1ps

module tb_cfg_decompressor
	import dcmp_stream_pkg::*;
	import dcmp_format_pkg::*;
();

	logic  clk;
	logic  nreset;
	logic  control_ready;
	byte_t flash_data;
	logic  flash_data_ready;
	logic  flash_data_read;
	byte_t fpga_data;
	logic  fpga_data_ready;
	logic  fpga_data_read;

	// compressed bytes not yet taken, expanded bytes not yet seen
	byte_t flash_q[$];
	byte_t expect_q[$];

	int recv_count;
	int total_expected;
	int flash_gap;
	int read_gap;
	bit flash_en;

	task automatic stop_on_error();
		$display("Errors found");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	`include "tb_stream_model.svh"

	cfg_decompressor uut (
		.clk              (clk),
		.nreset           (nreset),
		.control_ready    (control_ready),
		.flash_data       (flash_data),
		.flash_data_ready (flash_data_ready),
		.flash_data_read  (flash_data_read),
		.fpga_data        (fpga_data),
		.fpga_data_ready  (fpga_data_ready),
		.fpga_data_read   (fpga_data_read)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// flash source and FPGA sink
	////////////////////////////////////////////////////////////////////////////

	initial begin
		forever begin
			@(posedge clk);
			if (flash_data_ready && flash_data_read && flash_q.size() > 0)
				void'(flash_q.pop_front());
			@(negedge clk);
			// head byte offered with random gaps
			if (flash_en && flash_q.size() > 0 && $urandom_range(99) >= flash_gap) begin
				flash_data_ready = 1'b1;
				flash_data = flash_q[0];
			end else begin
				flash_data_ready = 1'b0;
			end
		end
	end

	initial begin
		forever begin
			@(negedge clk);
			fpga_data_read = ($urandom_range(99) >= read_gap);
		end
	end

	// compare each transferred byte with the reference
	// bytes beyond the expected stream only add to the count
	initial begin
		forever begin
			@(posedge clk);
			if (nreset && control_ready && fpga_data_ready && fpga_data_read) begin
				if (expect_q.size() > 0)
					check_byte("fpga_data", fpga_data, expect_q.pop_front());
				recv_count++;
			end
		end
	end

	task automatic queue_stream(input byte_q_t comp);
		byte_q_t plain;
		plain = expand(comp);
		total_expected += plain.size();
		expect_q = {expect_q, plain};
		flash_q = {flash_q, comp};
	endtask

	task automatic drain_stream(input string what);
		int t;
		t = 0;
		while (expect_q.size() != 0) begin
			if (t > 4000 + 20 * (flash_q.size() + expect_q.size())) begin
				$display("timeout: %s stream never finished, %0d bytes never arrived",
					what, expect_q.size());
				stop_on_error();
			end
			@(negedge clk);
			t++;
		end
		// idle window, the DUT must stay silent once the stream is done
		repeat (20) @(negedge clk);
		check_count("fpga byte count", recv_count, total_expected);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		byte_q_t s;
		int t;
		int base;
		void'($urandom(63995));
		nreset = 1'b0;
		control_ready = 1'b1;
		flash_data = '0;
		flash_data_ready = 1'b0;
		fpga_data_read = 1'b0;
		flash_en = 1'b1;
		flash_gap = 0;
		read_gap = 0;
		recv_count = 0;
		total_expected = 0;

		// raw runs from one byte up to extended lengths, offered during reset
		s.delete();
		add_raw(s, 0, 0);
		add_raw(s, 3, 0);
		add_raw(s, 15, 0);
		add_raw(s, 20, 0);
		add_raw(s, 45, 1);
		queue_stream(s);

		repeat (3) @(posedge clk);
		@(negedge clk);
		nreset = 1'b1;
		check_bit("fpga_data_ready", fpga_data_ready, 1'b0);
		check_bit("flash_data_read", flash_data_read, 1'b0);
		drain_stream("raw");

		// constant fills, codes 011 and 100 behave as zero fill
		s.delete();
		add_fill(s, 3'b000, 0, 8'h00, 0);
		add_fill(s, 3'b000, 7, 8'h00, 0);
		add_fill(s, 3'b111, 5, 8'h00, 0);
		add_fill(s, 3'b111, 30, 8'h00, 0);
		add_fill(s, 3'b011, 2, 8'h5A, 0);
		add_fill(s, 3'b100, 1, 8'h00, 1);
		queue_stream(s);
		drain_stream("fill");

		// variable fills mixed with every other kind
		s.delete();
		add_fill(s, 3'b010, 4, 8'hA5, 1);
		add_fill(s, 3'b010, 100, 8'h3C, 0);
		add_fill(s, 3'b010, 0, 8'h81, 0);
		add_raw(s, 9, 0);
		add_fill(s, 3'b111, 2, 8'h00, 0);
		add_raw(s, 0, 1);
		add_fill(s, 3'b000, 17, 8'h00, 0);
		queue_stream(s);
		drain_stream("mixed");

		// gaps on both sides
		flash_gap = 35;
		read_gap = 45;
		s.delete();
		random_runs(s, 40);
		queue_stream(s);
		drain_stream("random");

		// drop control_ready in the middle of a long fill
		// flash keeps offering bytes so the parser could still read
		flash_gap = 0;
		s.delete();
		add_fill(s, 3'b000, 400, 8'h00, 0);
		add_raw(s, 30, 0);
		queue_stream(s);
		base = recv_count;
		t = 0;
		while (recv_count - base < 20 || !fpga_data_ready) begin
			if (t > 5000) begin
				$display("timeout: fpga_data_ready never came up in the long fill");
				stop_on_error();
			end
			@(negedge clk);
			t++;
		end
		control_ready = 1'b0;
		@(negedge clk);
		check_bit("fpga_data_ready", fpga_data_ready, 1'b0);
		check_bit("flash_data_read", flash_data_read, 1'b0);
		flash_en = 1'b0;
		repeat (4) @(negedge clk);
		flash_q.delete();
		expect_q.delete();
		recv_count = 0;
		total_expected = 0;
		control_ready = 1'b1;
		flash_en = 1'b1;
		flash_gap = 35;

		// fresh stream after the restart
		s.delete();
		random_runs(s, 12);
		queue_stream(s);
		drain_stream("restart");

		$display("No errors");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+tests
common/dcmp_stream_pkg.sv
common/dcmp_format_pkg.sv
hw/sync_fifo.sv
decompressor/header_parser.sv
decompressor/run_emitter.sv
decompressor/cfg_decompressor.sv
tests/tb_cfg_decompressor.sv
